//--- xbarPkg.sv
// --------------------------------------------------
// Shared sizes and types for the flow crossbar
// Every RTL file refers to these by scoped name
// Flow counts, item width and destination ID width
// --------------------------------------------------

package xbarPkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------

  // Input flows, one pushDemux each
  localparam int numPushFlows = 4;

  // Output flows, one popMux and one arbiter each
  localparam int numPopFlows = 3;

  // Item payload width
  localparam int dataWidth = 16;

  // Binary destination index, wide enough for numPopFlows
  localparam int destIdWidth = 2;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------

  // One item payload
  typedef logic [dataWidth-1:0] dataT;

  // Binary pop flow index carried with each push item
  typedef logic [destIdWidth-1:0] destIdT;

  // One bit per push flow
  // Column requests, canGrant and grant use this
  typedef logic [numPushFlows-1:0] pushVecT;

  // One bit per pop flow
  // Row valid and pop vectors of a pushDemux
  typedef logic [numPopFlows-1:0] popVecT;

endpackage

//--- fixedPriorityArb.sv
// --------------------------------------------------
// Fixed priority arbiter for one crossbar column
// Lowest-indexed requester wins, purely combinational
// grant is qualified by colReady of the pop register
// --------------------------------------------------

`timescale 1ns/1ps

module fixedPriorityArb #(
  // Number of requesting push flows
  parameter int numRequesters = xbarPkg::numPushFlows
) (
  input  logic [numRequesters-1:0] request,
  input  logic                     colReady,
  output logic [numRequesters-1:0] canGrant,
  output logic [numRequesters-1:0] grant
);

  // --------------------------------------------------
  // Priority select
  // --------------------------------------------------

  // Isolate the lowest set bit
  // Adding one to the inverse carries up to that bit only
  always_comb begin
    canGrant = request & (~request + 1'b1);
  end

  // Column only takes an item when its pop register can
  always_comb begin
    if (colReady) begin
      grant = canGrant;
    end else begin
      grant = '0;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // At most one winner per column
  always_comb begin
    assert ($onehot0(canGrant))
      else $error("canGrant not one-hot: %b", canGrant);
  end

  // Never grant a flow that is not asking
  always_comb begin
    assert ((grant & ~request) == '0)
      else $error("grant %b outside request %b", grant, request);
  end

endmodule

//--- pushDemux.sv
// --------------------------------------------------
// Push side of one crossbar row
// Steers each push item by its destination ID into a
// one-entry crosspoint register per pop flow
// Registers empty when the column arbiter pops them
// --------------------------------------------------

`timescale 1ns/1ps

module pushDemux (
  input  logic                                        clk,
  input  logic                                        arstN,
  input  logic                                        pushValid,
  output logic                                        pushReady,
  input  xbarPkg::dataT                               pushData,
  input  xbarPkg::destIdT                             pushDestId,
  output xbarPkg::popVecT                             xpValid,
  output xbarPkg::dataT [xbarPkg::numPopFlows-1:0]    xpData,
  input  xbarPkg::popVecT                             xpPop
);

  xbarPkg::popVecT destOneHot;
  xbarPkg::popVecT xpFull;
  xbarPkg::popVecT slotFree;
  xbarPkg::popVecT load;
  logic            pushFire;

  // --------------------------------------------------
  // Destination decode
  // --------------------------------------------------

  // Out-of-range IDs decode to nothing and stall the flow
  always_comb begin
    for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
      destOneHot[j] = (pushDestId == xbarPkg::destIdT'(j));
    end
  end

  // Free when empty or being drained this cycle
  assign slotFree = ~xpFull | xpPop;

  // Ready looks only at the addressed crosspoint
  assign pushReady = |(destOneHot & slotFree);
  assign pushFire  = pushValid & pushReady;
  assign load      = destOneHot & {xbarPkg::numPopFlows{pushFire}};

  // --------------------------------------------------
  // Crosspoint registers
  // --------------------------------------------------

  // Pop and load in one cycle keeps the slot full
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      xpFull <= '0;
    end else begin
      xpFull <= (xpFull & ~xpPop) | load;
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
      if (load[j]) begin
        xpData[j] <= pushData;
      end
    end
  end

  assign xpValid = xpFull;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Source must name an existing pop flow
  assert property (@(posedge clk) disable iff (!arstN)
    pushValid |-> (pushDestId < xbarPkg::numPopFlows))
    else $error("pushDestId %0d out of range", pushDestId);

  // Column arbiters only grant occupied crosspoints
  assert property (@(posedge clk) disable iff (!arstN)
    (xpPop & ~xpFull) == '0)
    else $error("xpPop %b hits empty crosspoint, full %b", xpPop, xpFull);

endmodule

//--- popMux.sv
// --------------------------------------------------
// Pop side of one crossbar column
// Picks the crosspoint named by canGrant and moves it
// into a one-entry output register on the pop flow
// --------------------------------------------------

`timescale 1ns/1ps

module popMux (
  input  logic                                     clk,
  input  logic                                     arstN,
  input  xbarPkg::dataT [xbarPkg::numPushFlows-1:0] colData,
  input  xbarPkg::pushVecT                         canGrant,
  output logic                                     colReady,
  output logic                                     popValid,
  input  logic                                     popReady,
  output xbarPkg::dataT                            popData
);

  xbarPkg::dataT selData;
  logic          colGrant;

  // --------------------------------------------------
  // Data select
  // --------------------------------------------------

  // AND-OR mux over a one-hot select
  always_comb begin
    selData = '0;
    for (int i = 0; i < xbarPkg::numPushFlows; i++) begin
      if (canGrant[i]) begin
        selData = selData | colData[i];
      end
    end
  end

  // Room when empty or draining this cycle
  assign colReady = ~popValid | popReady;

  // Same condition the arbiter uses for its grant
  assign colGrant = (|canGrant) & colReady;

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // Hold while blocked, otherwise follow the column request
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      popValid <= 1'b0;
    end else if (colReady) begin
      popValid <= |canGrant;
    end
  end

  always_ff @(posedge clk) begin
    if (colGrant) begin
      popData <= selData;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Back-pressured output stays put until taken
  assert property (@(posedge clk) disable iff (!arstN)
    (popValid && !popReady) |=> (popValid && $stable(popData)))
    else $error("pop output changed while back-pressured");

endmodule

//--- flowXbarCore.sv
// --------------------------------------------------
// Crossbar datapath without the priority policy
// Rows of pushDemux feed columns of popMux
// Request and grant vectors leave for the arbiters
// --------------------------------------------------

`timescale 1ns/1ps

module flowXbarCore (
  input  logic                                            clk,
  input  logic                                            arstN,
  input  xbarPkg::pushVecT                                pushValid,
  output xbarPkg::pushVecT                                pushReady,
  input  xbarPkg::dataT    [xbarPkg::numPushFlows-1:0]    pushData,
  input  xbarPkg::destIdT  [xbarPkg::numPushFlows-1:0]    pushDestId,
  output xbarPkg::popVecT                                 popValid,
  input  xbarPkg::popVecT                                 popReady,
  output xbarPkg::dataT    [xbarPkg::numPopFlows-1:0]     popData,
  output xbarPkg::pushVecT [xbarPkg::numPopFlows-1:0]     request,
  output xbarPkg::popVecT                                 colReady,
  input  xbarPkg::pushVecT [xbarPkg::numPopFlows-1:0]     canGrant,
  input  xbarPkg::pushVecT [xbarPkg::numPopFlows-1:0]     grant
);

  // Row orientation, indexed [push][pop]
  xbarPkg::popVecT [xbarPkg::numPushFlows-1:0]                         xpValid;
  xbarPkg::popVecT [xbarPkg::numPushFlows-1:0]                         xpPop;
  xbarPkg::dataT   [xbarPkg::numPushFlows-1:0][xbarPkg::numPopFlows-1:0] rowData;

  // Column orientation, indexed [pop][push]
  xbarPkg::dataT   [xbarPkg::numPopFlows-1:0][xbarPkg::numPushFlows-1:0] colData;

  // --------------------------------------------------
  // Rows
  // --------------------------------------------------

  for (genvar i = 0; i < xbarPkg::numPushFlows; i++) begin : genRow
    pushDemux demuxInst (
      .clk        (clk),
      .arstN      (arstN),
      .pushValid  (pushValid[i]),
      .pushReady  (pushReady[i]),
      .pushData   (pushData[i]),
      .pushDestId (pushDestId[i]),
      .xpValid    (xpValid[i]),
      .xpData     (rowData[i]),
      .xpPop      (xpPop[i])
    );
  end

  // --------------------------------------------------
  // Transpose
  // --------------------------------------------------

  // Crosspoint [i][j] is request bit i of column j
  // and its grant comes back as pop bit j of row i
  always_comb begin
    for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
      for (int i = 0; i < xbarPkg::numPushFlows; i++) begin
        request[j][i] = xpValid[i][j];
        colData[j][i] = rowData[i][j];
        xpPop[i][j]   = grant[j][i];
      end
    end
  end

  // --------------------------------------------------
  // Columns
  // --------------------------------------------------

  for (genvar j = 0; j < xbarPkg::numPopFlows; j++) begin : genCol
    popMux muxInst (
      .clk      (clk),
      .arstN    (arstN),
      .colData  (colData[j]),
      .canGrant (canGrant[j]),
      .colReady (colReady[j]),
      .popValid (popValid[j]),
      .popReady (popReady[j]),
      .popData  (popData[j])
    );

    // Arbiter and pop register agree on when an item moves
    assert property (@(posedge clk) disable iff (!arstN)
      (|grant[j]) == (colReady[j] && (|request[j])))
      else $error("column %0d grant out of step with pop register", j);
  end

endmodule

//--- flowXbarFixed.sv
// --------------------------------------------------
// Flow crossbar with fixed priority arbitration
// Four push flows, three pop flows, ready/valid all over
// Push flow 0 has the highest priority in every column
// --------------------------------------------------

`timescale 1ns/1ps

module flowXbarFixed (
  input  logic                                         clk,
  input  logic                                         arstN,
  input  xbarPkg::pushVecT                             pushValid,
  output xbarPkg::pushVecT                             pushReady,
  input  xbarPkg::dataT   [xbarPkg::numPushFlows-1:0]  pushData,
  input  xbarPkg::destIdT [xbarPkg::numPushFlows-1:0]  pushDestId,
  output xbarPkg::popVecT                              popValid,
  input  xbarPkg::popVecT                              popReady,
  output xbarPkg::dataT   [xbarPkg::numPopFlows-1:0]   popData
);

  // Per column arbitration wires
  xbarPkg::pushVecT [xbarPkg::numPopFlows-1:0] request;
  xbarPkg::pushVecT [xbarPkg::numPopFlows-1:0] canGrant;
  xbarPkg::pushVecT [xbarPkg::numPopFlows-1:0] grant;
  xbarPkg::popVecT                             colReady;

  flowXbarCore coreInst (
    .clk        (clk),
    .arstN      (arstN),
    .pushValid  (pushValid),
    .pushReady  (pushReady),
    .pushData   (pushData),
    .pushDestId (pushDestId),
    .popValid   (popValid),
    .popReady   (popReady),
    .popData    (popData),
    .request    (request),
    .colReady   (colReady),
    .canGrant   (canGrant),
    .grant      (grant)
  );

  // One arbiter per pop column
  for (genvar j = 0; j < xbarPkg::numPopFlows; j++) begin : genArb
    fixedPriorityArb #(
      .numRequesters (xbarPkg::numPushFlows)
    ) arbInst (
      .request  (request[j]),
      .colReady (colReady[j]),
      .canGrant (canGrant[j]),
      .grant    (grant[j])
    );
  end

endmodule

//--- flowXbarFixedTb.sv
// --------------------------------------------------
// Testbench for the fixed priority flow crossbar
// Directed latency, priority and back-pressure tests,
// then random traffic and a drain at the end
// Concurrent assertions check every pop against
// per source and destination sequence counters
// --------------------------------------------------

`timescale 1ns/1ps

module flowXbarFixedTb;

  logic                                         clk;
  logic                                         arstN;
  xbarPkg::pushVecT                             pushValid;
  xbarPkg::pushVecT                             pushReady;
  xbarPkg::dataT   [xbarPkg::numPushFlows-1:0]  pushData;
  xbarPkg::destIdT [xbarPkg::numPushFlows-1:0]  pushDestId;
  xbarPkg::popVecT                              popValid;
  xbarPkg::popVecT                              popReady;
  xbarPkg::dataT   [xbarPkg::numPopFlows-1:0]   popData;

  // Sequence counters per source and destination pair
  int pushSeq [xbarPkg::numPushFlows][xbarPkg::numPopFlows];
  int popSeq  [xbarPkg::numPushFlows][xbarPkg::numPopFlows];
  int totalPushed;
  int totalPopped;
  int errorCount = 0;
  int blockCount;
  int prioPops;

  xbarPkg::pushVecT lastFire;
  xbarPkg::dataT    popExp [xbarPkg::numPopFlows];
  xbarPkg::popVecT  popOwed;
  logic             latencyArm;
  logic             prioArm;
  logic             blockArm;

  flowXbarFixed uut (
    .clk        (clk),
    .arstN      (arstN),
    .pushValid  (pushValid),
    .pushReady  (pushReady),
    .pushData   (pushData),
    .pushDestId (pushDestId),
    .popValid   (popValid),
    .popReady   (popReady),
    .popData    (popData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------

  // Payload holds source in [15:12], destination in [11:8], sequence in [7:0]
  always @(posedge clk or negedge arstN) begin : countBlock
    int pushes;
    int pops;
    pushes = 0;
    pops = 0;
    if (!arstN) begin
      for (int i = 0; i < xbarPkg::numPushFlows; i++) begin
        for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
          pushSeq[i][j] <= 0;
          popSeq[i][j]  <= 0;
        end
      end
      totalPushed <= 0;
      totalPopped <= 0;
      blockCount  <= 0;
      prioPops    <= 0;
      lastFire    <= '0;
    end else begin
      for (int i = 0; i < xbarPkg::numPushFlows; i++) begin
        if (pushValid[i] && pushReady[i]) begin
          pushSeq[i][pushDestId[i]] <= pushSeq[i][pushDestId[i]] + 1;
          pushes++;
        end
      end
      for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
        if (popValid[j] && popReady[j]) begin
          popSeq[popData[j][13:12]][j] <= popSeq[popData[j][13:12]][j] + 1;
          pops++;
        end
      end
      // Flow 3 into blocked column 1
      if (blockArm && pushValid[3] && pushReady[3] && pushDestId[3] == 2'd1) begin
        blockCount <= blockCount + 1;
      end
      if (prioArm && popValid[0] && popReady[0]) begin
        prioPops <= prioPops + 1;
      end
      totalPushed <= totalPushed + pushes;
      totalPopped <= totalPopped + pops;
      lastFire    <= pushValid & pushReady;
    end
  end

  // Next item owed to each pop flow as named by its source field
  always_comb begin
    for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
      popExp[j]  = {popData[j][15:12], 4'(j), 8'(popSeq[popData[j][13:12]][j])};
      popOwed[j] = (popData[j][15:12] < 4'(xbarPkg::numPushFlows)) &&
                   (popSeq[popData[j][13:12]][j] < pushSeq[popData[j][13:12]][j]);
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  function automatic void noteFailure(input string what);
    errorCount++;
    $display("Fail %0t: %s", $time, what);
  endfunction

  // Idle outputs right after reset release
  assert property (@(posedge clk) $rose(arstN) |-> (popValid == '0 && pushReady == '1))
    else noteFailure($sformatf("after reset popValid %b pushReady %b", popValid, pushReady));

  for (genvar j = 0; j < xbarPkg::numPopFlows; j++) begin : genPopCheck
    // Right destination, owed item, in order without gaps
    assert property (@(posedge clk) disable iff (!arstN)
      (popValid[j] && popReady[j]) |-> (popOwed[j] && popData[j] == popExp[j]))
      else noteFailure($sformatf("pop flow %0d gave %h, expected %h owed %b",
                                 j, popData[j], popExp[j], popOwed[j]));
    assert property (@(posedge clk) disable iff (!arstN)
      (popValid[j] && !popReady[j]) |=> (popValid[j] && $stable(popData[j])))
      else noteFailure($sformatf("pop flow %0d changed while stalled", j));
  end

  // Isolated push from flow 1 to pop flow 2
  assert property (@(posedge clk) disable iff (!arstN)
    (latencyArm && pushValid[1] && pushReady[1]) |-> ##1 !popValid[2] ##1 popValid[2])
    else noteFailure("pop flow 2 not valid exactly 2 cycles after the push");

  // Flow 0 beats flow 2 into column 0
  assert property (@(posedge clk) disable iff (!arstN)
    (prioArm && popValid[0] && popReady[0]) |->
    (popData[0][15:12] == ((prioPops == 0) ? 4'd0 : 4'd2)))
    else noteFailure($sformatf("priority pop %0d came from source %0d",
                               prioPops, popData[0][15:12]));

  // Crosspoint and pop register full so flow 3 must stall
  assert property (@(posedge clk) disable iff (!arstN)
    (blockArm && !popReady[1] && blockCount >= 2 && pushValid[3] &&
     pushDestId[3] == 2'd1) |-> !pushReady[3])
    else noteFailure("flow 3 accepted a push into the blocked column");

  // Other columns keep flowing
  assert property (@(posedge clk) disable iff (!arstN)
    (blockArm && pushValid[0]) |-> pushReady[0])
    else noteFailure("flow 0 stalled by a blocked column");

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  task automatic endRun();
    $display("Items pushed %0d, popped %0d, errors %0d", totalPushed, totalPopped, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic timeoutStop(input string what);
    errorCount++;
    $display("Timeout while waiting for %s", what);
    endRun();
  endtask

  task automatic presentItem(input int src, input int dest);
    pushValid[src]  = 1'b1;
    pushDestId[src] = xbarPkg::destIdT'(dest);
    pushData[src]   = {4'(src), 4'(dest), 8'(pushSeq[src][dest])};
  endtask

  // Drops each flow once its item was taken
  task automatic waitPushesDone(input string what);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      pushValid = pushValid & ~lastFire;
    end while (pushValid != '0 && waited < 200);
    if (pushValid != '0) timeoutStop(what);
  endtask

  task automatic waitIdle(input string what);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (totalPopped != totalPushed && waited < 500);
    if (totalPopped != totalPushed) timeoutStop(what);
  endtask

  // --------------------------------------------------
  // Test phases
  // --------------------------------------------------

  task automatic directedTests();
    int waited;
    int stallCycles;
    int flow0Dest;
    latencyArm = 1'b1;
    presentItem(1, 2);
    waitPushesDone("latency push");
    latencyArm = 1'b0;
    waitIdle("latency pop");
    prioArm = 1'b1;
    presentItem(0, 0);
    presentItem(2, 0);
    waitPushesDone("priority pushes");
    waitIdle("priority pops");
    prioArm = 1'b0;
    // Column 1 blocked while flow 0 alternates between columns 0 and 2
    popReady[1] = 1'b0;
    blockArm    = 1'b1;
    flow0Dest   = 0;
    presentItem(3, 1);
    presentItem(0, flow0Dest);
    waited = 0;
    stallCycles = 0;
    do begin
      @(negedge clk);
      waited++;
      if (lastFire[3]) presentItem(3, 1);
      if (lastFire[0]) begin
        flow0Dest = 2 - flow0Dest;
        presentItem(0, flow0Dest);
      end
      if (blockCount >= 2) stallCycles++;
    end while (stallCycles < 4 && waited < 100);
    if (stallCycles < 4) timeoutStop("blocked column to fill");
    popReady[1] = 1'b1;
    blockArm    = 1'b0;
    waitPushesDone("pushes after release");
    waitIdle("drain after release");
  endtask

  task automatic randomTraffic();
    int waited;
    int issued;
    waited = 0;
    issued = 0;
    do begin
      @(negedge clk);
      waited++;
      for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
        popReady[j] = 1'($urandom_range(1, 0));
      end
      for (int i = 0; i < xbarPkg::numPushFlows; i++) begin
        if (!pushValid[i] || lastFire[i]) begin
          if (issued < 400 && $urandom_range(1, 0) == 1) begin
            presentItem(i, int'($urandom_range(xbarPkg::numPopFlows - 1, 0)));
            issued++;
          end else begin
            pushValid[i] = 1'b0;
          end
        end
      end
    end while ((issued < 400 || pushValid != '0) && waited < 20000);
    if (issued < 400 || pushValid != '0) timeoutStop("random traffic to finish");
  endtask

  // Outputs quiet for a few cycles means nothing is left in flight
  task automatic drainCheck();
    int waited;
    int quiet;
    popReady = '1;
    waited = 0;
    quiet = 0;
    do begin
      @(negedge clk);
      waited++;
      if (popValid == '0) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end while (quiet < 4 && waited < 500);
    if (quiet < 4) timeoutStop("final drain");
    assert (totalPopped == totalPushed)
      else noteFailure($sformatf("drain popped %0d of %0d", totalPopped, totalPushed));
    for (int i = 0; i < xbarPkg::numPushFlows; i++) begin
      for (int j = 0; j < xbarPkg::numPopFlows; j++) begin
        assert (popSeq[i][j] == pushSeq[i][j])
          else noteFailure($sformatf("pair %0d to %0d lost items", i, j));
      end
    end
  endtask

  initial begin
    void'($urandom(65060));
    arstN      = 1'b0;
    pushValid  = '0;
    pushData   = '0;
    pushDestId = '0;
    popReady   = '1;
    latencyArm = 1'b0;
    prioArm    = 1'b0;
    blockArm   = 1'b0;
    repeat (8) @(negedge clk);
    arstN = 1'b1;
    repeat (2) @(negedge clk);
    directedTests();
    randomTraffic();
    drainCheck();
    endRun();
  end

endmodule

//--- flowXbarFixed.f
xbarPkg.sv
fixedPriorityArb.sv
pushDemux.sv
popMux.sv
flowXbarCore.sv
flowXbarFixed.sv
flowXbarFixedTb.sv

//--- Makefile
# Verilator build, run, lint and clean for the flow crossbar

VERILATOR  := verilator
TOP        := flowXbarFixedTb
RTL_TOP    := flowXbarFixed
FILELIST   := flowXbarFixed.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Errors found
PASS_MSG   := No errors
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
